// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_hss_rx -f src.f -o sim_hss_rx || exit 1
out=$(./obj_dir/sim_hss_rx)
echo "$out"
echo "$out" | grep -qxF "All tests passed" && exit 0 || exit 1

// ==== source/hss_rx_pkg.sv ====
package hss_rx_pkg;

  // ------------------------------
  // link characters
  // ------------------------------
  localparam logic [7:0] comma_chr = 8'hbc;  // K28.5
  localparam logic [7:0] sync_chr  = 8'h3c;  // K28.1, sync marker in code byte
  localparam logic [7:0] clkc_chr  = 8'hf7;  // K23.7, clock correction
  localparam logic [7:0] sof_chr   = 8'hfb;  // K27.7, start of frame
  localparam logic [7:0] eof_chr   = 8'hfd;  // K29.7, end of frame

  // ------------------------------
  // bring-up and frame limits
  // ------------------------------
  localparam int sync_bits = 7;
  localparam logic [sync_bits-1:0] sync_cnt = 7'd100;  // sync words per id
  localparam logic [7:0] frame_max_words = 8'd16;       // longest payload

  // comma lane, one-hot, as reported by the transceiver
  typedef logic [3:0] lane_t;
  localparam lane_t lane_none = 4'b0000;  // no comma seen yet
  localparam lane_t lane_b0   = 4'b0001;
  localparam lane_t lane_b1   = 4'b0010;
  localparam lane_t lane_b2   = 4'b0100;
  localparam lane_t lane_b3   = 4'b1000;

  // bring-up state, counts up only
  typedef enum logic [1:0] {
    link_idle,
    link_sync1,
    link_sync2,
    link_up
  } link_state_t;

  // word class set by the aligner
  localparam logic [1:0] kind_data = 2'd0;
  localparam logic [1:0] kind_sync = 2'd1;
  localparam logic [1:0] kind_clkc = 2'd2;

  // one aligned word, seen as payload or as control bytes
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [7:0] lead;  // comma / sof / eof
      logic [7:0] id;    // sync id or frame length
      logic [7:0] code;  // sync marker
      logic [7:0] tail;  // clkc char or checksum
    } ctl;
  } hss_word_u;

endpackage

// ==== source/hss_rx_top.sv ====
`timescale 1ns/1ps

module hss_rx_top (
  input  logic                    clk,
  input  logic                    rst,
  // transceiver side
  input  logic [31:0]             gtp_data,
  input  logic [3:0]              gtp_kchr,
  input  hss_rx_pkg::lane_t       gtp_is_comma,
  input  logic                    gtp_byte_is_aligned,
  input  logic [1:0]              gtp_los,
  output logic                    gtp_align_comma,
  // status
  output hss_rx_pkg::link_state_t rx_state,
  // frame output, no back-pressure
  output logic [31:0]             frm_data,
  output logic                    frm_vld,
  output logic                    frm_last,
  output logic                    frm_err
);
  import hss_rx_pkg::*;

  link_state_t link_state;  // live state, rx_state lags by one

  rx_word_if aw ();

  // ------------------------------
  // aligner -> sync ctrl / decoder
  // ------------------------------
  rx_aligner u_aligner (
    .clk                 (clk),
    .rst                 (rst),
    .gtp_data            (gtp_data),
    .gtp_kchr            (gtp_kchr),
    .gtp_is_comma        (gtp_is_comma),
    .gtp_byte_is_aligned (gtp_byte_is_aligned),
    .gtp_los             (gtp_los),
    .link_state          (link_state),
    .aw                  (aw.src)
  );

  rx_sync_ctrl u_sync_ctrl (
    .clk             (clk),
    .rst             (rst),
    .aw              (aw.sync_sink),
    .link_state      (link_state),
    .rx_state        (rx_state),
    .gtp_align_comma (gtp_align_comma)
  );

  rx_frame_decoder u_frame_decoder (
    .clk        (clk),
    .rst        (rst),
    .aw         (aw.frame_sink),
    .link_state (link_state),
    .frm_data   (frm_data),
    .frm_vld    (frm_vld),
    .frm_last   (frm_last),
    .frm_err    (frm_err)
  );

endmodule

// ==== source/rx_aligner.sv ====
`timescale 1ns/1ps

module rx_aligner (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [31:0]             gtp_data,
  input  logic [3:0]              gtp_kchr,
  input  hss_rx_pkg::lane_t       gtp_is_comma,
  input  logic                    gtp_byte_is_aligned,
  input  logic [1:0]              gtp_los,
  input  hss_rx_pkg::link_state_t link_state,
  rx_word_if.src                  aw
);
  import hss_rx_pkg::*;

  lane_t       lane;      // last comma lane seen
  logic [31:8] data_buf;  // bytes 3..1 of previous word
  logic [3:1]  kchr_buf;  // matching K flags
  logic        gtp_vld;
  hss_word_u   al_word;
  logic [3:0]  al_kchr;

  // ------------------------------
  // input qualification
  // ------------------------------
  // once up, byte_is_aligned no longer matters
  assign gtp_vld = (gtp_byte_is_aligned || (link_state == link_up)) && !gtp_los[1];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      lane <= lane_none;
    end else if (!gtp_vld) begin
      lane <= lane_none;  // sync lost, wait for a fresh comma
    end else if (gtp_is_comma != lane_none) begin
      lane <= gtp_is_comma;
    end
  end

  // previous word, upper bytes only
  always_ff @(posedge clk) begin
    if (gtp_vld) begin
      data_buf <= gtp_data[31:8];
      kchr_buf <= gtp_kchr[3:1];
    end
  end

  // ------------------------------
  // realignment
  // ------------------------------
  always_comb begin
    case (lane)
      lane_b0: begin
        al_word.raw = {gtp_data[7:0], data_buf[31:8]};
        al_kchr     = {gtp_kchr[0], kchr_buf[3:1]};
      end
      lane_b1: begin
        al_word.raw = {gtp_data[15:0], data_buf[31:16]};
        al_kchr     = {gtp_kchr[1:0], kchr_buf[3:2]};
      end
      lane_b2: begin
        al_word.raw = {gtp_data[23:0], data_buf[31:24]};
        al_kchr     = {gtp_kchr[2:0], kchr_buf[3]};
      end
      default: begin  // lane 3 is already aligned; with no lane vld is low anyway
        al_word.raw = gtp_data;
        al_kchr     = gtp_kchr;
      end
    endcase
  end

  // classify: sync = comma + marker, clkc = K in tail only
  always_comb begin
    aw.kind = kind_data;
    if ((al_kchr == 4'b1010) && (al_word.ctl.lead == comma_chr)
        && (al_word.ctl.code == sync_chr)) begin
      aw.kind = kind_sync;
    end else if ((al_kchr == 4'b0001) && (al_word.ctl.tail == clkc_chr)) begin
      aw.kind = kind_clkc;
    end
  end

  assign aw.word = al_word;
  assign aw.kchr = al_kchr;
  assign aw.vld  = gtp_vld && (lane != lane_none);

endmodule

// ==== source/rx_frame_decoder.sv ====
`timescale 1ns/1ps

module rx_frame_decoder (
  input  logic                    clk,
  input  logic                    rst,
  rx_word_if.frame_sink           aw,
  input  hss_rx_pkg::link_state_t link_state,
  output logic [31:0]             frm_data,
  output logic                    frm_vld,
  output logic                    frm_last,
  output logic                    frm_err
);
  import hss_rx_pkg::*;

  logic        take, is_sof, is_eof, is_dat, close;
  logic        id_bad;
  logic        in_frm;     // between sof and eof
  logic [7:0]  len;        // announced length
  logic        len_bad;
  logic [7:0]  cnt;        // data words so far
  logic [7:0]  cnt_inc;
  logic [7:0]  csum;       // running xor of data bytes
  logic [7:0]  word_x;
  logic        hold_vld;   // last (or surplus) word waiting for eof
  logic [31:0] hold_data;
  logic        hold_now;
  logic        load_hold;
  logic        emit_vld, emit_last, emit_err;
  logic [31:0] emit_data;

  // ------------------------------
  // word decode
  // ------------------------------
  assign take    = aw.vld && (aw.kind == kind_data) && (link_state == link_up);
  assign is_sof  = (aw.kchr == 4'b1000) && (aw.word.ctl.lead == sof_chr);
  assign is_eof  = (aw.kchr == 4'b1000) && (aw.word.ctl.lead == eof_chr);
  assign is_dat  = take && in_frm && !is_sof && !is_eof;
  assign close   = take && in_frm && (is_sof || is_eof);  // sof here = missing eof
  assign id_bad  = (aw.word.ctl.id == 8'd0) || (aw.word.ctl.id > frame_max_words);
  assign cnt_inc = (cnt == 8'hff) ? cnt : cnt + 8'd1;
  assign word_x  = aw.word.ctl.lead ^ aw.word.ctl.id ^ aw.word.ctl.code ^ aw.word.ctl.tail;

  // hold once the announced count is reached; bad length holds every word
  assign hold_now = hold_vld || len_bad || (cnt_inc >= len);

  always_comb begin
    emit_vld  = 1'b0;
    emit_last = 1'b0;
    emit_err  = 1'b0;
    emit_data = aw.word.raw;
    load_hold = 1'b0;
    if (close) begin
      emit_vld  = 1'b1;
      emit_last = 1'b1;
      emit_data = hold_vld ? hold_data : '0;  // empty/short frame gives a zero marker
      emit_err  = is_sof || len_bad || (cnt != len) || (csum != aw.word.ctl.tail);
    end else if (is_dat) begin
      load_hold = hold_now;
      if (hold_vld) begin
        emit_vld  = 1'b1;  // surplus word pushes the older one out
        emit_data = hold_data;
      end else if (!hold_now) begin
        emit_vld  = 1'b1;  // straight through, one cycle
      end
    end
  end

  // ------------------------------
  // frame state and outputs
  // ------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      in_frm   <= 1'b0;
      len      <= '0;
      len_bad  <= 1'b0;
      cnt      <= '0;
      csum     <= '0;
      hold_vld <= 1'b0;
      frm_vld  <= 1'b0;
      frm_last <= 1'b0;
      frm_err  <= 1'b0;
    end else begin
      frm_vld  <= emit_vld;
      frm_last <= emit_last;
      frm_err  <= emit_err;
      if (take && is_sof) begin
        in_frm   <= 1'b1;  // also reopens after a missing eof
        len      <= aw.word.ctl.id;
        len_bad  <= id_bad;
        cnt      <= '0;
        csum     <= '0;
        hold_vld <= 1'b0;
      end else if (close) begin
        in_frm   <= 1'b0;
        hold_vld <= 1'b0;
      end else if (is_dat) begin
        cnt      <= cnt_inc;
        csum     <= csum ^ word_x;
        hold_vld <= hold_now;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (emit_vld) begin
      frm_data <= emit_data;
    end
    if (load_hold) begin
      hold_data <= aw.word.raw;
    end
  end

endmodule

// ==== source/rx_sync_ctrl.sv ====
`timescale 1ns/1ps

module rx_sync_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  rx_word_if.sync_sink            aw,
  output hss_rx_pkg::link_state_t link_state,
  output hss_rx_pkg::link_state_t rx_state,
  output logic                    gtp_align_comma
);
  import hss_rx_pkg::*;

  logic [sync_bits-1:0] cnt [4];  // one per sync id
  logic                 is_sync;
  logic [1:0]           cur_id;   // id the current state waits on
  logic [1:0]           nxt_id;   // id of the next state
  logic                 step;

  assign is_sync = aw.vld && (aw.kind == kind_sync);

  // ------------------------------
  // sync counters
  // ------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 4; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        // saturate, never wrap back below sync_cnt
        if (is_sync && (aw.word.ctl.id == 8'(i)) && (cnt[i] != '1)) begin
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

  // ------------------------------
  // bring-up FSM
  // ------------------------------
  assign cur_id = link_state;
  assign nxt_id = cur_id + 2'd1;

  // enough of our own id, or far side already moved on
  assign step = (cnt[cur_id] >= sync_cnt) || (cnt[nxt_id] > sync_cnt);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      link_state <= link_idle;
    end else if ((link_state != link_up) && step) begin
      link_state <= link_state_t'(nxt_id);  // one step per clock
    end
  end

  // status copy, one cycle behind
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rx_state <= link_idle;
    end else begin
      rx_state <= link_state;
    end
  end

  // comma align request held until link is up, then released for good
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      gtp_align_comma <= 1'b1;
    end else if (link_state == link_up) begin
      gtp_align_comma <= 1'b0;
    end
  end

endmodule

// ==== source/rx_word_if.sv ====
`timescale 1ns/1ps

// aligned word from the aligner, fanned out to sync ctrl and frame decoder
interface rx_word_if;
  import hss_rx_pkg::*;

  hss_word_u  word;  // comma-aligned word
  logic [3:0] kchr;  // K flags, same alignment as word
  logic       vld;   // per-cycle strobe, no handshake
  logic [1:0] kind;  // kind_data / kind_sync / kind_clkc

  modport src (output word, kchr, vld, kind);

  // sync ctrl only needs the id byte and class
  modport sync_sink (input word, vld, kind);

  modport frame_sink (input word, kchr, vld, kind);

endinterface

// ==== src.f ====
+incdir+tb
source/hss_rx_pkg.sv
source/rx_word_if.sv
source/rx_aligner.sv
source/rx_sync_ctrl.sv
source/rx_frame_decoder.sv
source/hss_rx_top.sv
tb/tb_hss_rx.sv

// ==== tb/tb_hss_rx_tasks.svh ====
// ------------------------------
// transceiver side
// ------------------------------
// the comma lane splits each logical word over two transceiver words,
// so the stream on the wire runs one logical word behind
task automatic push_word(input hss_word_u w, input logic [3:0] k);
  logic [63:0] dpair;
  logic [7:0]  kpair;
  dpair = {w.raw, pend_w.raw} >> (8 * (3 - lane_idx));
  kpair = {k, pend_k} >> (3 - lane_idx);
  @(negedge clk);
  gtp_data     = dpair[31:0];
  gtp_kchr     = kpair[3:0];
  gtp_is_comma = lane_none;
  if (pend_k[3] && (pend_w.raw[31:24] == comma_chr)) begin
    gtp_is_comma = lane_t'(4'b0001 << lane_idx);  // comma byte on the wire now
  end
  pend_w = w;
  pend_k = k;
endtask

task automatic push_idle();
  push_word({comma_chr, 24'h0}, 4'b1000);
endtask

task automatic push_sync(input logic [7:0] id);
  push_word({comma_chr, id, sync_chr, 8'h00}, 4'b1010);
endtask

// sof, payload, eof with xor of every payload byte
task automatic send_frame(input hss_word_u pay[$], input logic [7:0] len,
                          input logic bad_csum, input logic fill);
  logic [7:0] csum;
  csum = 8'h00;
  push_word({sof_chr, len, 16'h0}, 4'b1000);
  foreach (pay[i]) begin
    push_word(pay[i], 4'b0000);
    for (int b = 0; b < 4; b++) begin
      csum ^= pay[i].raw[8*b +: 8];
    end
    if (fill && (i < pay.size() - 1)) begin
      push_word({24'h0, clkc_chr}, 4'b0001);  // clock correction
      push_sync(8'd3);
    end
  end
  push_word({eof_chr, 16'h0, bad_csum ? ~csum : csum}, 4'b1000);
endtask

task automatic wait_for_last(input int n);
  while (last_cnt < n) begin
    push_idle();  // also flushes the half-sent word
  end
endtask

task automatic clear_output();
  out_data.delete();
  out_last.delete();
  out_err.delete();
  last_cnt = 0;
endtask

// ------------------------------
// compares
// ------------------------------
task automatic check_word(input string name, input hss_word_u exp, input hss_word_u act);
  if (act !== exp) begin
    err_cnt++;
    $display("FAIL t=%0t %s expected %08h got %08h", $time, name, exp.raw, act.raw);
  end
endtask

task automatic check_state(input string name, input link_state_t exp, input link_state_t act);
  if (act !== exp) begin
    err_cnt++;
    $display("FAIL t=%0t %s expected %s got %s", $time, name, exp.name(), act.name());
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    err_cnt++;
    $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
  end
endtask

task automatic expect_no_output(input string what);
  if (out_data.size() != 0) begin
    err_cnt++;
    $display("frame output seen %s: %0d words", what, out_data.size());
  end
endtask

task automatic check_frame(input hss_word_u pay[$]);
  wait_for_last(1);
  if (out_data.size() != pay.size()) begin
    err_cnt++;
    $display("frame came out with %0d words, %0d were sent", out_data.size(), pay.size());
  end else begin
    foreach (pay[i]) begin
      check_word("frm_data", pay[i], out_data[i]);
      check_bit("frm_last", (i == pay.size() - 1), out_last[i]);
      check_bit("frm_err", 1'b0, out_err[i]);
    end
  end
endtask

// error flag on the n-th frame end since the last clear
task automatic check_nth_end(input int n, input logic exp_err);
  int seen;
  wait_for_last(n);
  seen = 0;
  foreach (out_last[i]) begin
    if (out_last[i]) begin
      seen++;
      if (seen == n) begin
        check_bit("frm_err", exp_err, out_err[i]);
      end
    end
  end
endtask

task automatic finish_test(input string name, input int errs_before);
  test_cnt++;
  if (err_cnt == errs_before) begin
    $display("test %-16s ok", name);
  end else begin
    test_fail++;
    $display("test %-16s %0d errors", name, err_cnt - errs_before);
  end
endtask

// ------------------------------
// directed tests
// ------------------------------
task automatic test_reset_state();
  int e0;
  e0 = err_cnt;
  clear_output();
  repeat (8) begin
    push_idle();
    check_bit("gtp_align_comma", 1'b1, gtp_align_comma);
    check_state("rx_state", link_idle, rx_state);
    check_bit("frm_vld", 1'b0, frm_vld);
  end
  finish_test("reset_state", e0);
endtask

task automatic test_bring_up();
  int          e0;
  link_state_t exp_st [4] = '{link_sync1, link_sync2, link_up, link_up};
  e0 = err_cnt;
  clear_output();
  for (int id = 0; id < 4; id++) begin
    repeat (int'(sync_cnt)) push_sync(8'(id));
    repeat (4) push_idle();  // count, step, status copy
    check_state("rx_state", exp_st[id], rx_state);
  end
  check_bit("gtp_align_comma", 1'b0, gtp_align_comma);
  expect_no_output("during bring-up");
  finish_test("bring_up", e0);
endtask

task automatic test_lane_realign();
  int        e0;
  hss_word_u pay[$];
  e0 = err_cnt;
  lane_idx = 1;
  repeat (3) push_idle();  // aligner picks up the new lane
  clear_output();
  repeat (4) pay.push_back($urandom());
  send_frame(pay, 8'd4, 1'b0, 1'b0);
  check_frame(pay);
  finish_test("lane_realign", e0);
endtask

task automatic test_filtering();
  int        e0;
  hss_word_u pay[$];
  e0 = err_cnt;
  clear_output();
  repeat (5) pay.push_back($urandom());
  send_frame(pay, 8'd5, 1'b0, 1'b1);
  check_frame(pay);
  finish_test("filtering", e0);
endtask

task automatic test_frame_errors();
  int        e0;
  hss_word_u pay[$];
  e0 = err_cnt;
  repeat (4) pay.push_back($urandom());
  clear_output();
  send_frame(pay, 8'd4, 1'b1, 1'b0);  // bad checksum
  check_nth_end(1, 1'b1);
  clear_output();
  send_frame(pay, 8'd5, 1'b0, 1'b0);  // one word short
  check_nth_end(1, 1'b1);
  clear_output();
  push_word({sof_chr, 8'd4, 16'h0}, 4'b1000);
  push_word(pay[0], 4'b0000);
  push_word(pay[1], 4'b0000);
  send_frame(pay, 8'd4, 1'b0, 1'b0);  // sof before eof
  check_nth_end(1, 1'b1);
  check_nth_end(2, 1'b0);
  finish_test("frame_errors", e0);
endtask

task automatic test_loss_of_signal();
  int        e0;
  hss_word_u pay[$];
  e0 = err_cnt;
  clear_output();
  repeat (3) pay.push_back($urandom());
  @(negedge clk);
  gtp_los = 2'b10;
  send_frame(pay, 8'd3, 1'b0, 1'b0);
  repeat (6) push_idle();
  expect_no_output("with loss of signal");
  @(negedge clk);
  gtp_los = 2'b00;
  repeat (2) push_idle();  // fresh comma, lane back
  pay.delete();
  repeat (3) pay.push_back($urandom());
  send_frame(pay, 8'd3, 1'b0, 1'b0);
  check_frame(pay);
  finish_test("loss_of_signal", e0);
endtask

// ==== tb/tb_hss_rx.sv ====
`timescale 1ns/1ps

module tb_hss_rx;
  import hss_rx_pkg::*;

  // run limit: bring-up sync words plus a handful of frames, doubled
  localparam int bringup_cycles = 4 * (int'(sync_cnt) + 8);
  localparam int frame_cycles   = 8 * (int'(frame_max_words) + 12);
  localparam int max_cycles     = 2 * (bringup_cycles + frame_cycles) + 400;

  logic        clk;
  logic        rst;
  logic [31:0] gtp_data;
  logic [3:0]  gtp_kchr;
  lane_t       gtp_is_comma;
  logic        gtp_byte_is_aligned;
  logic [1:0]  gtp_los;
  logic        gtp_align_comma;
  link_state_t rx_state;
  logic [31:0] frm_data;
  logic        frm_vld;
  logic        frm_last;
  logic        frm_err;

  hss_word_u   pend_w;          // logical word still half on the wire
  logic [3:0]  pend_k;
  int          lane_idx;        // comma byte position, 0..3
  hss_word_u   out_data[$];     // collected frame output
  logic        out_last[$];
  logic        out_err[$];
  int          last_cnt = 0;    // frm_last strobes seen
  int          cycles = 0;
  int          err_cnt = 0;
  int          test_cnt = 0;
  int          test_fail = 0;

  hss_rx_top u_hss_rx_top (
    .clk                 (clk),
    .rst                 (rst),
    .gtp_data            (gtp_data),
    .gtp_kchr            (gtp_kchr),
    .gtp_is_comma        (gtp_is_comma),
    .gtp_byte_is_aligned (gtp_byte_is_aligned),
    .gtp_los             (gtp_los),
    .gtp_align_comma     (gtp_align_comma),
    .rx_state            (rx_state),
    .frm_data            (frm_data),
    .frm_vld             (frm_vld),
    .frm_last            (frm_last),
    .frm_err             (frm_err)
  );

  `include "tb_hss_rx_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------
  // output capture and timeout
  // ------------------------------
  always @(negedge clk) begin
    if (frm_vld) begin  // registered outputs, stable mid-cycle
      out_data.push_back(frm_data);
      out_last.push_back(frm_last);
      out_err.push_back(frm_err);
      if (frm_last) begin
        last_cnt++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(73219));
    rst                 = 1'b1;
    gtp_data            = '0;
    gtp_kchr            = '0;
    gtp_is_comma        = lane_none;
    gtp_byte_is_aligned = 1'b1;
    gtp_los             = 2'b00;
    pend_w              = '0;
    pend_k              = '0;
    lane_idx            = 3;  // start byte aligned
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_reset_state();
    test_bring_up();
    test_lane_realign();
    test_filtering();
    test_frame_errors();
    test_loss_of_signal();

    $display("%0d tests, %0d failed, %0d check errors", test_cnt, test_fail, err_cnt);
    if (test_fail == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
